// File: src.f
+incdir+include
verilog/thread_ctrl_pkg.sv
verilog/io_bus_arbiter.sv
verilog/interrupt_controller.sv
verilog/interval_timer.sv
verilog/thread_ctrl_top.sv
verif/thread_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the thread control testbench with Verilator and run it
# A failing check ends the run through $fatal, so the exit status is nonzero

set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f src.f \
	--top-module thread_ctrl_tb \
	-o sim_thread_ctrl

./obj_dir/sim_thread_ctrl

// File: verif/thread_ctrl_tb.sv
// Thread control subsystem testbench
// Drives both bus ports, irq lines and acks, checks outputs against a cycle model

`include "thread_ctrl_defines.svh"

module thread_ctrl_tb import thread_ctrl_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int TIMER_PERIOD = 12;
	// Cycle budget per bus access and per serviced interrupt
	localparam int ACCESSES = 50;
	localparam int ACCESS_CYCLES = 8;
	localparam int SERVICES = 12;
	localparam int SERVICE_CYCLES = 12;
	localparam int TEST_CYCLES = 5 + ACCESSES * ACCESS_CYCLES
		+ SERVICES * SERVICE_CYCLES + 5 * (TIMER_PERIOD + 1) + 20;

	logic clk;
	logic reset;
	wb_req_t host_req;
	wb_rsp_t host_rsp;
	wb_req_t core_req;
	wb_rsp_t core_rsp;
	logic [`INT_SOURCES-2:0] ext_irq;
	logic [`TOTAL_THREADS-1:0] interrupt_ack;
	logic [`TOTAL_THREADS-1:0] thread_en;
	logic [`TOTAL_THREADS-1:0] interrupt_pending;
	interrupt_id_t [`TOTAL_THREADS-1:0] interrupt_id;
	logic processor_halt;

	// Reference model state
	logic [`TOTAL_THREADS-1:0] m_en;
	logic [`TOTAL_THREADS-1:0] m_pend;
	interrupt_id_t [`TOTAL_THREADS-1:0] m_id;
	logic [`INT_SOURCES-1:0] m_latched;
	logic [`INT_SOURCES-1:0] m_irq_prev;
	logic [2*`INT_SOURCES-1:0] m_route;
	logic [`IO_DATA_WIDTH-1:0] m_period;
	logic [`IO_DATA_WIDTH-1:0] m_count;
	logic m_tmr_en;
	logic m_tick;

	string test_name;
	integer seed;
	int cycle_count;

	thread_ctrl_top UUT (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.core_req(core_req),
		.core_rsp(core_rsp),
		.ext_irq(ext_irq),
		.interrupt_ack(interrupt_ack),
		.thread_en(thread_en),
		.interrupt_pending(interrupt_pending),
		.interrupt_id(interrupt_id),
		.processor_halt(processor_halt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	task automatic fail_run();
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
			fail_run();
		end
	endtask

	// Lowest latched source routed to thread t or -1 when none
	function automatic int lowest_source(input int t);
		for (int s = 0; s < `INT_SOURCES; s++)
		begin
			if (m_latched[s] && int'(m_route[2*s +: 2]) == t)
				return s;
		end
		return -1;
	endfunction

	function automatic logic [31:0] expected_read(input logic [7:0] adr);
		case (adr)
			REG_THREAD_EN: return 32'(m_en);
			REG_ROUTE: return 32'(m_route);
			REG_PENDING: return 32'(m_latched);
			TMR_PERIOD: return m_period;
			TMR_CTRL: return 32'(m_tmr_en);
			default: return '0;
		endcase
	endfunction

	task automatic model_reset();
		m_en = `TOTAL_THREADS'(1);
		m_pend = '0;
		m_id = '0;
		m_latched = '0;
		m_irq_prev = '0;
		m_route = '0;
		m_period = '0;
		m_count = '0;
		m_tmr_en = 1'b0;
		m_tick = 1'b0;
	endtask

	// One clock of the interrupt rules with inputs as they stood before the edge
	task automatic model_step();
		logic [`INT_SOURCES-1:0] irq_now;
		logic [`INT_SOURCES-1:0] taken;
		int s;
		irq_now = {ext_irq, m_tick};
		taken = '0;
		for (int t = 0; t < `TOTAL_THREADS; t++)
		begin
			s = lowest_source(t);
			if (m_en[t] && !m_pend[t] && s >= 0)
			begin
				m_pend[t] = 1'b1;
				m_id[t] = interrupt_id_t'(s);
				taken[s] = 1'b1;
			end
			else if (interrupt_ack[t])
				m_pend[t] = 1'b0;
		end
		m_latched = (m_latched & ~taken) | (irq_now & ~m_irq_prev);
		m_irq_prev = irq_now;
		// Timer ticks when the count reaches the period
		if (!m_tmr_en)
		begin
			m_count = '0;
			m_tick = 1'b0;
		end
		else if (m_count == m_period)
		begin
			m_count = '0;
			m_tick = 1'b1;
		end
		else
		begin
			m_count = m_count + 1;
			m_tick = 1'b0;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
			model_reset();
		else
			model_step();
	end

	// Register effect of a write applied just after its ack edge
	task automatic apply_write(input logic [7:0] adr, input logic [31:0] d);
		case (adr)
			REG_RESUME: m_en = m_en | d[`TOTAL_THREADS-1:0];
			REG_HALT: m_en = m_en & ~d[`TOTAL_THREADS-1:0];
			REG_ROUTE: m_route = d[2*`INT_SOURCES-1:0];
			TMR_PERIOD:
			begin
				m_period = d;
				m_count = '0;
				m_tick = 1'b0;
			end
			TMR_CTRL: m_tmr_en = d[0];
			default: ;
		endcase
	endtask

	// One Wishbone classic access on the host (core=0) or core (core=1) port
	task automatic bus_access(input bit core, input bit we, input logic [7:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		wb_req_t req;
		wb_rsp_t rsp;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.adr = adr;
		req.dat = wdata;
		@(posedge clk);
		#2;
		if (core)
			core_req = req;
		else
			host_req = req;
		// Hold the request until ack since the arbiter may keep us waiting
		do
		begin
			@(posedge clk);
			#1;
			rsp = core ? core_rsp : host_rsp;
		end
		while (!rsp.ack);
		rdata = rsp.dat;
		if (we)
			apply_write(adr, wdata);
		#1;
		if (core)
			core_req = '0;
		else
			host_req = '0;
	endtask

	task automatic bus_write(input bit core, input logic [7:0] adr, input logic [31:0] d);
		logic [31:0] unused;
		bus_access(core, 1'b1, adr, d, unused);
	endtask

	task automatic read_check(input bit core, input logic [7:0] adr, input string what);
		logic [31:0] expected;
		logic [31:0] rdata;
		expected = expected_read(adr);
		bus_access(core, 1'b0, adr, '0, rdata);
		check_equal(what, expected, rdata);
	endtask

	task automatic pulse_irq(input logic [`INT_SOURCES-2:0] lines);
		@(posedge clk);
		#2;
		ext_irq = lines;
		@(posedge clk);
		#2;
		ext_irq = '0;
	endtask

	// Wait for thread t to raise pending, check its id, then ack it
	task automatic service(input int t, input int id, output int seen);
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!interrupt_pending[t]);
		seen = cycle_count;
		check_equal($sformatf("interrupt_id[%0d]", t), id, interrupt_id[t]);
		#1;
		interrupt_ack[t] = 1'b1;
		@(posedge clk);
		#2;
		interrupt_ack[t] = 1'b0;
	endtask

	// Compare outputs at the falling edge where they are stable
	always @(negedge clk)
	begin
		if (!reset)
		begin
			check_equal("thread_en", m_en, thread_en);
			check_equal("interrupt_pending", m_pend, interrupt_pending);
			check_equal("interrupt_id", m_id, interrupt_id);
			check_equal("processor_halt", m_en == '0, processor_halt);
		end
	end

	initial
	begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Error: watchdog expired before the tests finished");
		fail_run();
	end

	initial
	begin
		logic [31:0] rnd;
		logic [7:0] route_val;
		int seen;
		int prev;
		clk = 1'b0;
		reset = 1'b1;
		host_req = '0;
		core_req = '0;
		ext_irq = '0;
		interrupt_ack = '0;
		seed = 32'hbf18_8b0f;
		cycle_count = 0;
		test_name = "reset";
		model_reset();
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		read_check(1'b0, REG_THREAD_EN, "thread_en read");
		// Unmapped address still completes with zero data
		read_check(1'b1, 8'h40, "unmapped read");

		test_name = "resume_halt";
		for (int i = 0; i < 20; i++)
		begin
			rnd = $random(seed);
			bus_write(rnd[0], rnd[1] ? REG_HALT : REG_RESUME, 32'(rnd[7:4]));
		end
		bus_write(1'b0, REG_HALT, 32'hf);
		check_equal("halt after halting all", 1, processor_halt);
		bus_write(1'b1, REG_RESUME, 32'h1);
		check_equal("halt after resume", 0, processor_halt);
		read_check(1'b1, REG_THREAD_EN, "thread_en read");

		test_name = "contention";
		fork
			bus_write(1'b0, REG_RESUME, 32'b0110);
			bus_write(1'b1, REG_HALT, 32'b1001);
		join
		check_equal("mask after disjoint writes", 4'b0110, thread_en);
		rnd = $random(seed);
		fork
			bus_write(1'b0, REG_ROUTE, 32'(rnd[7:0]));
			bus_write(1'b1, TMR_PERIOD, $random(seed));
		join
		read_check(1'b1, REG_ROUTE, "route read");
		read_check(1'b0, TMR_PERIOD, "period read");
		read_check(1'b0, REG_THREAD_EN, "thread_en read");

		test_name = "routing";
		bus_write(1'b0, REG_RESUME, 32'hf);
		// Sources 1, 2, 3 go to threads 2, 1, 3
		route_val = 8'b11_01_10_00;
		bus_write(1'b1, REG_ROUTE, 32'(route_val));
		for (int s = 1; s < `INT_SOURCES; s++)
		begin
			pulse_irq(3'(1 << (s - 1)));
			service(int'(route_val[2*s +: 2]), s, seen);
		end
		// All external sources on thread 3 and lowest delivered first
		bus_write(1'b0, REG_ROUTE, 32'hfc);
		pulse_irq(3'b111);
		for (int s = 1; s < `INT_SOURCES; s++)
			service(3, s, seen);

		test_name = "halted_target";
		bus_write(1'b0, REG_HALT, 32'b0100);
		bus_write(1'b1, REG_ROUTE, 32'h08);
		pulse_irq(3'b001);
		repeat (4) @(posedge clk);
		read_check(1'b0, REG_PENDING, "latched sources");
		bus_write(1'b1, REG_RESUME, 32'b0100);
		service(2, 1, seen);

		test_name = "timer";
		bus_write(1'b0, REG_ROUTE, 32'h00);
		bus_write(1'b0, TMR_PERIOD, TIMER_PERIOD);
		bus_write(1'b1, TMR_CTRL, 32'h1);
		read_check(1'b0, TMR_CTRL, "timer enable read");
		service(0, 0, prev);
		for (int i = 0; i < 4; i++)
		begin
			service(0, 0, seen);
			check_equal("tick interval", TIMER_PERIOD + 1, seen - prev);
			prev = seen;
		end
		bus_write(1'b1, TMR_CTRL, 32'h0);
		read_check(1'b1, TMR_CTRL, "timer disable read");
		repeat (4) @(posedge clk);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: verilog/thread_ctrl_top.sv
// Thread control subsystem top level
// Arbiter shares the IO bus between host and cores, timer feeds source 0

`include "thread_ctrl_defines.svh"

module thread_ctrl_top import thread_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input wb_req_t host_req,
	output wb_rsp_t host_rsp,
	input wb_req_t core_req,
	output wb_rsp_t core_rsp,
	input logic [`INT_SOURCES-2:0] ext_irq,
	input logic [`TOTAL_THREADS-1:0] interrupt_ack,
	output logic [`TOTAL_THREADS-1:0] thread_en,
	output logic [`TOTAL_THREADS-1:0] interrupt_pending,
	output interrupt_id_t [`TOTAL_THREADS-1:0] interrupt_id,
	output logic processor_halt
);

	// Shared slave side of the IO bus
	wb_req_t slave_req;
	wb_rsp_t ic_rsp;
	wb_rsp_t tmr_rsp;
	logic ic_stb;
	logic tmr_stb;
	logic tick;

	io_bus_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.core_req(core_req),
		.core_rsp(core_rsp),
		.slave_req(slave_req),
		.ic_stb(ic_stb),
		.tmr_stb(tmr_stb),
		.ic_rsp(ic_rsp),
		.tmr_rsp(tmr_rsp)
	);

	// Timer tick sits below the external lines as source 0
	interrupt_controller ic (
		.clk(clk),
		.reset(reset),
		.bus_req(slave_req),
		.bus_stb(ic_stb),
		.bus_rsp(ic_rsp),
		.irq({ext_irq, tick}),
		.thread_en(thread_en),
		.interrupt_pending(interrupt_pending),
		.interrupt_id(interrupt_id),
		.processor_halt(processor_halt),
		.interrupt_ack(interrupt_ack)
	);

	interval_timer timer (
		.clk(clk),
		.reset(reset),
		.bus_req(slave_req),
		.bus_stb(tmr_stb),
		.bus_rsp(tmr_rsp),
		.tick(tick)
	);

endmodule

// File: verilog/interval_timer.sv
// Interval timer
// Periodic counter that pulses tick every period+1 cycles while enabled

`include "thread_ctrl_defines.svh"

module interval_timer import thread_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input wb_req_t bus_req,
	input logic bus_stb,
	output wb_rsp_t bus_rsp,
	output logic tick
);

	logic [`IO_DATA_WIDTH-1:0] period;
	logic [`IO_DATA_WIDTH-1:0] count;
	logic enable;
	logic ack;
	logic period_write;
	logic [`IO_DATA_WIDTH-1:0] rd_data;

	assign period_write = bus_stb && bus_req.we && !ack && bus_req.adr == TMR_PERIOD;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			period <= '0;
			enable <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			ack <= bus_stb && !ack;
			if (period_write)
				period <= bus_req.dat;
			if (bus_stb && bus_req.we && !ack && bus_req.adr == TMR_CTRL)
				enable <= bus_req.dat[0];
		end
	end

	// Counter restarts on a period write, idles at zero while disabled
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (!enable || period_write)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (count == period)
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus_stb && !ack)
			rd_data <= (bus_req.adr == TMR_PERIOD) ? period
				: (bus_req.adr == TMR_CTRL) ? `IO_DATA_WIDTH'(enable) : '0;
	end

	assign bus_rsp.ack = ack;
	assign bus_rsp.dat = rd_data;

endmodule

// File: verilog/interrupt_controller.sv
// Interrupt controller
// Thread enable mask, edge-latched sources and per-thread routed dispatch

`include "thread_ctrl_defines.svh"

module interrupt_controller import thread_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input wb_req_t bus_req,
	input logic bus_stb,
	output wb_rsp_t bus_rsp,
	input logic [`INT_SOURCES-1:0] irq,
	output logic [`TOTAL_THREADS-1:0] thread_en,
	output logic [`TOTAL_THREADS-1:0] interrupt_pending,
	output interrupt_id_t [`TOTAL_THREADS-1:0] interrupt_id,
	output logic processor_halt,
	input logic [`TOTAL_THREADS-1:0] interrupt_ack
);

	localparam int THREAD_BITS = $clog2(`TOTAL_THREADS);

	// Target thread per source
	logic [`INT_SOURCES-1:0][THREAD_BITS-1:0] route;
	logic [`INT_SOURCES-1:0] irq_prev;
	logic [`INT_SOURCES-1:0] latched;
	logic [`INT_SOURCES-1:0] dispatch_clear;
	logic [`TOTAL_THREADS-1:0] dispatch_valid;
	interrupt_id_t [`TOTAL_THREADS-1:0] dispatch_id;
	logic ack;
	logic bus_write;
	logic [`IO_DATA_WIDTH-1:0] rd_data;

	// A write takes effect once, in the cycle its ack is raised
	assign bus_write = bus_stb && bus_req.we && !ack;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Thread 0 runs out of reset
			thread_en <= `TOTAL_THREADS'(1);
			route <= '0;
			ack <= 1'b0;
		end
		else
		begin
			ack <= bus_stb && !ack;
			if (bus_write)
			begin
				case (bus_req.adr)
					REG_RESUME:
						thread_en <= thread_en | bus_req.dat[`TOTAL_THREADS-1:0];
					REG_HALT:
						thread_en <= thread_en & ~bus_req.dat[`TOTAL_THREADS-1:0];
					REG_ROUTE:
						route <= bus_req.dat[`INT_SOURCES*THREAD_BITS-1:0];
					default:
						;
				endcase
			end
		end
	end

	// Halt once every thread is stopped
	assign processor_halt = thread_en == '0;

	// Read data captured with the ack
	always_ff @(posedge clk)
	begin
		if (bus_stb && !ack)
		begin
			case (bus_req.adr)
				REG_THREAD_EN: rd_data <= `IO_DATA_WIDTH'(thread_en);
				REG_ROUTE: rd_data <= `IO_DATA_WIDTH'(route);
				REG_PENDING: rd_data <= `IO_DATA_WIDTH'(latched);
				default: rd_data <= '0;
			endcase
		end
	end

	assign bus_rsp.ack = ack;
	assign bus_rsp.dat = rd_data;

	// Per thread, lowest latched source routed to it
	always_comb
	begin
		dispatch_valid = '0;
		dispatch_id = '0;
		dispatch_clear = '0;
		for (int t = 0; t < `TOTAL_THREADS; t++)
		begin
			// Disabled or busy threads leave their sources latched
			if (thread_en[t] && !interrupt_pending[t])
			begin
				// Scan downward so the lowest match is kept
				for (int s = `INT_SOURCES - 1; s >= 0; s--)
				begin
					if (latched[s] && route[s] == THREAD_BITS'(t))
					begin
						dispatch_valid[t] = 1'b1;
						dispatch_id[t] = interrupt_id_t'(s);
					end
				end
				if (dispatch_valid[t])
					dispatch_clear[dispatch_id[t]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			irq_prev <= '0;
			latched <= '0;
			interrupt_pending <= '0;
			interrupt_id <= '0;
		end
		else
		begin
			irq_prev <= irq;
			// Fresh edge wins over a clear in the same cycle
			latched <= (latched & ~dispatch_clear) | (irq & ~irq_prev);
			for (int t = 0; t < `TOTAL_THREADS; t++)
			begin
				if (dispatch_valid[t])
				begin
					interrupt_pending[t] <= 1'b1;
					interrupt_id[t] <= dispatch_id[t];
				end
				else if (interrupt_ack[t])
					interrupt_pending[t] <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/io_bus_arbiter.sv
// IO bus arbiter
// Round-robin grant between host and core masters, window decode to two slaves

`include "thread_ctrl_defines.svh"

module io_bus_arbiter import thread_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	input wb_req_t host_req,
	output wb_rsp_t host_rsp,
	input wb_req_t core_req,
	output wb_rsp_t core_rsp,
	output wb_req_t slave_req,
	output logic ic_stb,
	output logic tmr_stb,
	input wb_rsp_t ic_rsp,
	input wb_rsp_t tmr_rsp
);

	localparam logic [`IO_ADDR_WIDTH-1:0] IC_ADDR = `IC_BASE;
	localparam logic [`IO_ADDR_WIDTH-1:0] TMR_ADDR = `TIMER_BASE;

	grant_e grant;
	grant_e next_grant;
	// Set when the core port held the last grant
	logic last_core;
	logic owner_busy;
	logic ic_win;
	logic tmr_win;
	logic access;
	logic dflt_ack;
	wb_rsp_t sel_rsp;

	// Owner keeps the bus until it lets go of cyc
	assign owner_busy = (grant == GRANT_HOST && host_req.cyc)
		|| (grant == GRANT_CORE && core_req.cyc);

	always_comb
	begin
		next_grant = grant;
		if (!owner_busy)
		begin
			// Both asking, the one not served last goes first
			if (host_req.cyc && core_req.cyc)
				next_grant = last_core ? GRANT_HOST : GRANT_CORE;
			else if (host_req.cyc)
				next_grant = GRANT_HOST;
			else if (core_req.cyc)
				next_grant = GRANT_CORE;
			else
				next_grant = GRANT_NONE;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			grant <= GRANT_NONE;
			last_core <= 1'b0;
		end
		else
		begin
			grant <= next_grant;
			if (next_grant == GRANT_HOST)
				last_core <= 1'b0;
			else if (next_grant == GRANT_CORE)
				last_core <= 1'b1;
		end
	end

	// Shared slave bus carries only the owner's request
	assign slave_req = (grant == GRANT_HOST) ? host_req
		: (grant == GRANT_CORE) ? core_req : '0;

	// Window decode on the upper address bits
	assign ic_win = slave_req.adr[`IO_ADDR_WIDTH-1:`IO_WINDOW_BITS]
		== IC_ADDR[`IO_ADDR_WIDTH-1:`IO_WINDOW_BITS];
	assign tmr_win = slave_req.adr[`IO_ADDR_WIDTH-1:`IO_WINDOW_BITS]
		== TMR_ADDR[`IO_ADDR_WIDTH-1:`IO_WINDOW_BITS];
	assign access = slave_req.cyc && slave_req.stb;
	assign ic_stb = access && ic_win;
	assign tmr_stb = access && tmr_win;

	// Unmapped address still completes, one ack per access
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dflt_ack <= 1'b0;
		else
			dflt_ack <= access && !ic_win && !tmr_win && !dflt_ack;
	end

	// Pick the answering slave, unmapped reads return zero
	always_comb
	begin
		sel_rsp.ack = ic_rsp.ack || tmr_rsp.ack || dflt_ack;
		if (ic_win)
			sel_rsp.dat = ic_rsp.dat;
		else if (tmr_win)
			sel_rsp.dat = tmr_rsp.dat;
		else
			sel_rsp.dat = '0;
	end

	// Only the grant owner sees the response
	assign host_rsp = (grant == GRANT_HOST) ? sel_rsp : '0;
	assign core_rsp = (grant == GRANT_CORE) ? sel_rsp : '0;

endmodule

// File: verilog/thread_ctrl_pkg.sv
// Thread control package
// Wishbone bundles, register map, arbiter state and interrupt id type

`include "thread_ctrl_defines.svh"

package thread_ctrl_pkg;

	// Wishbone classic master to slave bundle
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`IO_ADDR_WIDTH-1:0] adr;
		logic [`IO_DATA_WIDTH-1:0] dat;
	} wb_req_t;

	// Slave to master bundle
	typedef struct packed {
		logic ack;
		logic [`IO_DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	// Register offsets, each value is its window base plus the offset
	typedef enum logic [`IO_ADDR_WIDTH-1:0] {
		REG_RESUME    = `IC_BASE + 8'h00,
		REG_HALT      = `IC_BASE + 8'h04,
		REG_THREAD_EN = `IC_BASE + 8'h08,
		REG_ROUTE     = `IC_BASE + 8'h0C,
		REG_PENDING   = `IC_BASE + 8'h10,
		TMR_PERIOD    = `TIMER_BASE + 8'h00,
		TMR_CTRL      = `TIMER_BASE + 8'h04
	} io_reg_e;

	typedef enum logic [1:0] {GRANT_NONE, GRANT_HOST, GRANT_CORE} grant_e;

	typedef logic [1:0] interrupt_id_t;

endpackage

// File: include/thread_ctrl_defines.svh
// Thread control subsystem parameters
// Thread and interrupt source counts, IO bus widths and register windows

`ifndef THREAD_CTRL_DEFINES_SVH
`define THREAD_CTRL_DEFINES_SVH

// Hardware threads in the cluster
`define TOTAL_THREADS 4

// Interrupt sources, source 0 is the interval timer
`define INT_SOURCES 4

// IO bus widths
`define IO_ADDR_WIDTH 8
`define IO_DATA_WIDTH 32

// Each slave owns a 32 byte window
`define IO_WINDOW_BITS 5

// Window base addresses
`define IC_BASE 8'h00
`define TIMER_BASE 8'h20

`endif
